/* design/link_buffer_settings.svh */
// Link buffer settings
`ifndef LINK_BUFFER_SETTINGS_SVH
`define LINK_BUFFER_SETTINGS_SVH

// fifo entries, also the producer's starting credits.
`define LB_DEPTH 16

// bits per entry.
`define LB_DATA_WIDTH 8

// almost_full is set at or above this occupancy.
`define LB_AF_THRESH 12

// almost_empty is set at or below this occupancy.
`define LB_AE_THRESH 4

// credits granted by the consumer after reset.
`define LB_OUT_CREDITS 4

`endif

/* design/link_buffer_pkg.sv */
// Link buffer types
`include "link_buffer_settings.svh"

package link_buffer_pkg;

    // one buffered byte.
    typedef logic [`LB_DATA_WIDTH-1:0] data_t;

    // occupancy from 0 to depth inclusive, hence the extra bit.
    typedef logic [$clog2(`LB_DEPTH):0] count_t;

    // downstream credits from 0 to LB_OUT_CREDITS.
    typedef logic [$clog2(`LB_OUT_CREDITS + 1)-1:0] credit_t;

endpackage

/* design/fifo_pop_if.sv */
// FIFO pop interface
`timescale 1ns/1ps

interface fifo_pop_if;

    // pop request from the egress stage.
    logic                     pop;

    // head entry, loaded on the edge that takes a pop.
    link_buffer_pkg::data_t   rd_data;

    logic                     empty;

    // current occupancy.
    link_buffer_pkg::count_t  level;

    modport fifo (
        input  pop,
        output rd_data,
        output empty,
        output level
    );

    modport egress (
        output pop,
        input  rd_data,
        input  empty
    );

endinterface

/* design/fifo_ctrl.sv */
// Synchronous FIFO controller
`timescale 1ns/1ps
`include "link_buffer_settings.svh"

module fifo_ctrl (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   wr_en,
    input  link_buffer_pkg::data_t wr_data,
    output logic                   full,
    output logic                   almost_full,
    output logic                   almost_empty,
    fifo_pop_if.fifo               pop_port
);

    localparam int ADDR_W = $clog2(`LB_DEPTH);

    localparam logic [ADDR_W-1:0] LAST_ADDR = ADDR_W'(`LB_DEPTH - 1);

    link_buffer_pkg::data_t  mem [`LB_DEPTH];

    logic [ADDR_W-1:0]       wr_ptr;
    logic [ADDR_W-1:0]       rd_ptr;
    link_buffer_pkg::count_t count;
    link_buffer_pkg::data_t  rd_data_q;

    logic                    do_write;
    logic                    do_read;
    logic                    empty;

    // flags come straight from the count.
    assign full         = (count == link_buffer_pkg::count_t'(`LB_DEPTH));
    assign empty        = (count == '0);
    assign almost_full  = (count >= link_buffer_pkg::count_t'(`LB_AF_THRESH));
    assign almost_empty = (count <= link_buffer_pkg::count_t'(`LB_AE_THRESH));

    // a write while full is dropped.
    assign do_write = wr_en && !full;
    assign do_read  = pop_port.pop && !empty;

    assign pop_port.empty   = empty;
    assign pop_port.level   = count;
    assign pop_port.rd_data = rd_data_q;

    // pointers wrap at the last entry.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (do_write) begin
                wr_ptr <= (wr_ptr == LAST_ADDR) ? '0 : wr_ptr + 1'b1;
            end
            if (do_read) begin
                rd_ptr <= (rd_ptr == LAST_ADDR) ? '0 : rd_ptr + 1'b1;
            end
        end
    end

    // write and read together leave the count alone.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count <= '0;
        end else begin
            case ({do_write, do_read})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (do_write) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    // the registered read port holds until the next pop.
    always_ff @(posedge clk) begin
        if (do_read) begin
            rd_data_q <= mem[rd_ptr];
        end
    end

    // the upstream credit loop must keep the producer from overrunning.
    a_no_write_when_full: assert property (
        @(posedge clk) disable iff (!rst_n)
        !(wr_en && full)
    ) else $error("fifo_ctrl: write while full");

    // egress must respect empty.
    a_no_pop_when_empty: assert property (
        @(posedge clk) disable iff (!rst_n)
        pop_port.pop |-> !empty
    ) else $error("fifo_ctrl: pop while empty");

endmodule

/* design/credit_egress.sv */
// Credit-based egress stage
`timescale 1ns/1ps
`include "link_buffer_settings.svh"

module credit_egress (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   out_credit,
    output logic                   out_valid,
    output link_buffer_pkg::data_t out_data,
    output logic                   in_credit,
    fifo_pop_if.egress             pop_port
);

    localparam link_buffer_pkg::credit_t MAX_CREDITS =
        link_buffer_pkg::credit_t'(`LB_OUT_CREDITS);

    link_buffer_pkg::credit_t credits;
    logic                     pop;

    // pop only with data waiting and a credit in hand.
    assign pop          = !pop_port.empty && (credits != '0);
    assign pop_port.pop = pop;

    // spend on pop, refill on out_credit.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            credits <= MAX_CREDITS;
        end else begin
            case ({pop, out_credit})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits;
            endcase
        end
    end

    // one beat downstream and one credit upstream per pop.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            in_credit <= 1'b0;
        end else begin
            out_valid <= pop;
            in_credit <= pop;
        end
    end

    // the FIFO read register already holds the popped byte.
    assign out_data = pop_port.rd_data;

    // the consumer never returns more than it was given.
    a_credit_bound: assert property (
        @(posedge clk) disable iff (!rst_n)
        credits <= MAX_CREDITS
    ) else $error("credit_egress: credit count above limit");

endmodule

/* design/occupancy_monitor.sv */
// Peak occupancy monitor
`timescale 1ns/1ps
`include "link_buffer_settings.svh"

module occupancy_monitor (
    input  logic                    clk,
    input  logic                    rst_n,
    input  link_buffer_pkg::count_t level,
    output link_buffer_pkg::count_t peak_level
);

    logic new_peak;

    // high-water mark read out for sizing links in the field.
    assign new_peak = (level > peak_level);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            peak_level <= '0;
        end else if (new_peak) begin
            peak_level <= level;
        end
    end

    // the mark only ever climbs.
    a_peak_monotonic: assert property (
        @(posedge clk) disable iff (!rst_n)
        peak_level >= $past(peak_level)
    ) else $error("occupancy_monitor: peak decreased");

endmodule

/* design/link_buffer_top.sv */
// Credit-managed link buffer
`timescale 1ns/1ps
`include "link_buffer_settings.svh"

module link_buffer_top (
    input  logic                    clk,
    input  logic                    rst_n,

    // upstream side.
    input  logic                    in_valid,
    input  link_buffer_pkg::data_t  in_data,
    output logic                    in_credit,

    // downstream side.
    output logic                    out_valid,
    output link_buffer_pkg::data_t  out_data,
    input  logic                    out_credit,

    // status.
    output logic                    full,
    output logic                    almost_full,
    output logic                    almost_empty,
    output link_buffer_pkg::count_t peak_level
);

    fifo_pop_if pop_if ();

    fifo_ctrl i_fifo_ctrl (
        .clk          (clk),
        .rst_n        (rst_n),
        .wr_en        (in_valid),
        .wr_data      (in_data),
        .full         (full),
        .almost_full  (almost_full),
        .almost_empty (almost_empty),
        .pop_port     (pop_if.fifo)
    );

    credit_egress i_credit_egress (
        .clk        (clk),
        .rst_n      (rst_n),
        .out_credit (out_credit),
        .out_valid  (out_valid),
        .out_data   (out_data),
        .in_credit  (in_credit),
        .pop_port   (pop_if.egress)
    );

    // level is tapped off the pop interface.
    occupancy_monitor i_occupancy_monitor (
        .clk        (clk),
        .rst_n      (rst_n),
        .level      (pop_if.level),
        .peak_level (peak_level)
    );

endmodule

/* verif/tb_link_buffer.sv */
// Link buffer testbench
`timescale 1ns/1ps
`include "link_buffer_settings.svh"

module tb_link_buffer;

    localparam int CLK_PERIOD   = 8;
    localparam int RESET_CYCLES = 16;
    localparam int NUM_BYTES    = 200;
    localparam int FILL_LIMIT   = 200;
    localparam int DRAIN_LIMIT  = 400;

    localparam int SEND_NONE   = 0;
    localparam int SEND_RANDOM = 1;
    localparam int SEND_ALWAYS = 2;

    logic                    clk;
    logic                    rst_n;
    logic                    in_valid;
    link_buffer_pkg::data_t  in_data;
    logic                    in_credit;
    logic                    out_valid;
    link_buffer_pkg::data_t  out_data;
    logic                    out_credit;
    logic                    full;
    logic                    almost_full;
    logic                    almost_empty;
    link_buffer_pkg::count_t peak_level;

    // reference state.
    link_buffer_pkg::data_t  sent_q[$];
    int                      credit_due[$];
    int                      producer_credits;
    int                      bytes_sent;
    int                      cycle;
    int                      model_lag;
    int                      exp_count;
    int                      exp_peak;
    int                      outstanding;
    logic [31:0]             rng_state;
    string                   test_name;

    link_buffer_top i_dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .in_valid     (in_valid),
        .in_data      (in_data),
        .in_credit    (in_credit),
        .out_valid    (out_valid),
        .out_data     (out_data),
        .out_credit   (out_credit),
        .full         (full),
        .almost_full  (almost_full),
        .almost_empty (almost_empty),
        .peak_level   (peak_level)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #((NUM_BYTES * 40 + RESET_CYCLES) * CLK_PERIOD);
        $display("watchdog: the run went past its time limit");
        $display("** FAIL **");
        $fatal(1, "watchdog expired");
    end

    task automatic value_error(input string check, input longint expected,
                               input longint actual);
        $display("ERROR %s %s: expected %0d, actual %0d", test_name, check, expected, actual);
        $display("** FAIL **");
        $fatal(1, "stopping after a failed check");
    endtask

    task automatic stop_with_reason(input string reason);
        $display("%s: %s", test_name, reason);
        $display("** FAIL **");
        $fatal(1, "stopping after a failed check");
    endtask

    function automatic logic [31:0] next_random();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    // the model count lags by one edge because a pop only shows up as in_credit.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            model_lag   <= 0;
            exp_peak    <= 0;
            outstanding <= 0;
        end else begin
            model_lag   <= model_lag + int'(in_valid) - int'(in_credit);
            outstanding <= outstanding + int'(out_valid) - int'(out_credit);
            if (exp_count > exp_peak) begin
                exp_peak <= exp_count;
            end
        end
    end

    always_comb begin
        exp_count = model_lag - int'(in_credit);
    end

    // every beat must match the oldest byte still in flight.
    always @(posedge clk) begin
        if (rst_n && out_valid) begin
            if (sent_q.size() == 0) begin
                stop_with_reason("out_valid seen with no byte in flight");
            end else begin
                assert (out_data == sent_q[0])
                    else value_error("order", sent_q[0], out_data);
                void'(sent_q.pop_front());
            end
        end
    end

    a_full: assert property (@(posedge clk) disable iff (!rst_n)
        full == (exp_count == `LB_DEPTH))
        else value_error("full", $sampled(exp_count) == `LB_DEPTH, $sampled(full));

    a_almost_full: assert property (@(posedge clk) disable iff (!rst_n)
        almost_full == (exp_count >= `LB_AF_THRESH))
        else value_error("almost_full", $sampled(exp_count) >= `LB_AF_THRESH,
                         $sampled(almost_full));

    a_almost_empty: assert property (@(posedge clk) disable iff (!rst_n)
        almost_empty == (exp_count <= `LB_AE_THRESH))
        else value_error("almost_empty", $sampled(exp_count) <= `LB_AE_THRESH,
                         $sampled(almost_empty));

    a_peak: assert property (@(posedge clk) disable iff (!rst_n)
        int'(peak_level) == exp_peak)
        else value_error("peak_level", $sampled(exp_peak), $sampled(peak_level));

    a_downstream_credit: assert property (@(posedge clk) disable iff (!rst_n)
        outstanding <= `LB_OUT_CREDITS)
        else value_error("downstream credits at most", `LB_OUT_CREDITS,
                         $sampled(outstanding));

    // one clock of traffic with inputs changing 1 ns after the edge.
    task automatic advance_cycle(input int send_mode, input bit return_ok);
        int                     found;
        int                     i;
        bit                     send;
        link_buffer_pkg::data_t data;
        @(posedge clk);
        #1;
        cycle++;
        // the consumer frees each beat's slot 0 to 7 cycles later.
        if (out_valid) begin
            credit_due.push_back(cycle + int'(next_random() % 8));
        end
        found = -1;
        if (return_ok) begin
            for (i = 0; i < credit_due.size(); i++) begin
                if (found < 0 && credit_due[i] <= cycle) begin
                    found = i;
                end
            end
        end
        if (found >= 0) begin
            credit_due.delete(found);
            out_credit = 1'b1;
        end else begin
            out_credit = 1'b0;
        end
        if (in_credit) begin
            producer_credits++;
        end
        assert (producer_credits <= `LB_DEPTH)
            else value_error("upstream credits at most", `LB_DEPTH, producer_credits);
        send = 1'b0;
        if (producer_credits > 0) begin
            if (send_mode == SEND_ALWAYS) begin
                send = 1'b1;
            end else if (send_mode == SEND_RANDOM) begin
                send = (next_random() & 32'h1) != 0;
            end
        end
        if (send) begin
            data = link_buffer_pkg::data_t'(next_random() >> 8);
            in_valid = 1'b1;
            in_data  = data;
            producer_credits--;
            sent_q.push_back(data);
            bytes_sent++;
        end else begin
            in_valid = 1'b0;
        end
    endtask

    task automatic check_reset_state();
        test_name = "reset";
        assert (out_valid == 1'b0) else value_error("out_valid", 0, out_valid);
        assert (in_credit == 1'b0) else value_error("in_credit", 0, in_credit);
        assert (full == 1'b0) else value_error("full", 0, full);
        assert (almost_full == 1'b0) else value_error("almost_full", 0, almost_full);
        assert (almost_empty == 1'b1) else value_error("almost_empty", 1, almost_empty);
        assert (peak_level == '0) else value_error("peak_level", 0, peak_level);
    endtask

    task automatic measure_latency();
        int edges;
        test_name = "latency";
        advance_cycle(SEND_ALWAYS, 1'b1);
        edges = 0;
        // first counted edge takes the byte, the second raises out_valid.
        while (!out_valid && edges < 8) begin
            advance_cycle(SEND_NONE, 1'b1);
            edges++;
        end
        if (!out_valid) begin
            stop_with_reason("a single byte never reached out_valid");
        end else begin
            assert (edges == 2) else value_error("latency edges", 2, edges);
        end
    endtask

    task automatic drain_buffer();
        int waited;
        test_name = "drain";
        waited = 0;
        while ((sent_q.size() != 0 || credit_due.size() != 0) && waited < DRAIN_LIMIT) begin
            advance_cycle(SEND_NONE, 1'b1);
            waited++;
        end
        if (waited >= DRAIN_LIMIT) begin
            stop_with_reason("the buffer did not drain in time");
        end else begin
            // let the last returned credit land.
            repeat (2) advance_cycle(SEND_NONE, 1'b1);
            assert (producer_credits == `LB_DEPTH)
                else value_error("upstream credits after drain", `LB_DEPTH, producer_credits);
        end
    endtask

    task automatic fill_buffer();
        int waited;
        test_name = "fill";
        waited = 0;
        while (!full && waited < FILL_LIMIT) begin
            advance_cycle(SEND_RANDOM, 1'b0);
            waited++;
        end
        if (!full) begin
            stop_with_reason("the FIFO never filled while credits were held back");
        end else begin
            advance_cycle(SEND_NONE, 1'b0);
            assert (int'(peak_level) == `LB_DEPTH)
                else value_error("peak after fill", `LB_DEPTH, peak_level);
        end
    endtask

    task automatic random_traffic();
        test_name = "random";
        while (bytes_sent < NUM_BYTES) begin
            // one window in three the consumer sits on its credits.
            advance_cycle(SEND_RANDOM, ((cycle / 24) % 3) != 2);
        end
    endtask

    initial begin
        rng_state        = 32'hc33b3bfe;
        rst_n            = 1'b0;
        in_valid         = 1'b0;
        in_data          = '0;
        out_credit       = 1'b0;
        producer_credits = `LB_DEPTH;
        bytes_sent       = 0;
        cycle            = 0;
        test_name        = "reset";
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst_n = 1'b1;
        check_reset_state();
        measure_latency();
        drain_buffer();
        fill_buffer();
        drain_buffer();
        random_traffic();
        drain_buffer();
        $display("** PASS **");
        $finish;
    end

endmodule

/* filelist.f */
+incdir+design
design/link_buffer_pkg.sv
design/fifo_pop_if.sv
design/fifo_ctrl.sv
design/credit_egress.sv
design/occupancy_monitor.sv
design/link_buffer_top.sv
verif/tb_link_buffer.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the link buffer testbench with Verilator.

cd "$(dirname "$0")" || exit 1

if ! command -v verilator >/dev/null 2>&1; then
    echo "verilator is not on the PATH"
    exit 1
fi

verilator --binary --timing --assert \
    --top-module tb_link_buffer \
    -f filelist.f \
    -o sim_link_buffer
status=$?
if [ "$status" -ne 0 ]; then
    echo "build failed with status $status"
    exit 1
fi

output=$(./obj_dir/sim_link_buffer 2>&1)
status=$?
printf '%s\n' "$output"
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qxF '** PASS **'; then
    exit 0
fi
echo "pass message not found in the simulation output"
exit 1
